// ==== icache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_checker (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire icache_pkg::fetch_req_t fetch_req,
    input  wire logic                   req_ready,
    input  wire icache_pkg::fetch_rsp_t fetch_rsp,
    input  wire icache_pkg::wb_m2s_t    wb_m,
    input  wire logic                   wb_ack,
    output int                          error_count,
    output int                          pending,        // responses still owed
    output int                          hit_count,
    output int                          miss_count
);
    import icache_pkg::*;

    typedef struct packed {
        logic [31:0] addr;
        logic        hit;                                // model prediction
        logic [31:0] cycle;                              // accept cycle
    } expect_t;

    expect_t     exp_q[$];                               // accepted, not yet answered
    tag_t        model_tag   [2][num_sets];
    logic        model_valid [2][num_sets];
    logic        model_lru   [num_sets];                 // way to evict next
    int          cycle;
    logic        reset_q;
    logic        miss_open;                              // refill owed or running
    logic [31:0] fill_base;                              // byte address of refill line
    int          fill_words;                             // refill reads seen so far

    // xor with a constant, then rotate left by address bits 6..2
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        logic [4:0]  r;
        x = addr ^ 32'h5a3c_96e1;
        r = addr[6:2];
        return (x << r) | (x >> (6'd32 - {1'b0, r}));
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    // hit or miss by the replacement rule, then update the model
    task automatic accept_request(input logic [31:0] addr);
        logic [19:0] tag;
        logic [7:0]  set;
        logic        hit;
        logic        way;
        tag = addr[31:12];
        set = addr[11:4];
        hit = 1'b1;
        way = 1'b0;
        if (model_valid[0][set] && (model_tag[0][set] == tag)) begin
            way = 1'b0;
        end else if (model_valid[1][set] && (model_tag[1][set] == tag)) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            if (!model_valid[0][set]) way = 1'b0;        // invalid way first
            else if (!model_valid[1][set]) way = 1'b1;
            else way = model_lru[set];
            model_tag[way][set]   = tag;
            model_valid[way][set] = 1'b1;
            miss_open  = 1'b1;
            fill_base  = {addr[31:4], 4'h0};
            fill_words = 0;
        end
        if (hit) hit_count++;
        else miss_count++;
        model_lru[set] = ~way;                           // other way goes next
        exp_q.push_back('{addr: addr, hit: hit, cycle: cycle});
    endtask

    task automatic check_bus();
        logic [31:0] want;
        if (wb_m.cyc && !miss_open) begin
            report_error("Wishbone cycle without a predicted miss");
        end
        if (wb_m.stb && (wb_m.we || (wb_m.sel != 4'hf))) begin
            report_error("Wishbone read with we set or sel not all ones");
        end
        if (wb_m.cyc && wb_m.stb && wb_ack && miss_open) begin
            want = fill_base + (fill_words << 2);        // words 0..3 in order
            if (fill_words >= words_per_line) begin
                report_error($sformatf("extra refill read at %h", wb_m.adr));
            end else if (wb_m.adr != want) begin
                report_error($sformatf("refill read %0d at %h, expected %h",
                                       fill_words, wb_m.adr, want));
            end
            fill_words++;
        end
    endtask

    task automatic check_response();
        expect_t e;
        if (!fetch_rsp.valid) return;
        if (exp_q.size() == 0) begin
            report_error("response with no request outstanding");
            return;
        end
        e = exp_q.pop_front();                           // responses in request order
        if (fetch_rsp.data !== mem_word(e.addr)) begin
            report_error($sformatf("addr %h returned %h, expected %h",
                                   e.addr, fetch_rsp.data, mem_word(e.addr)));
        end
        if (e.hit && ((cycle - int'(e.cycle)) != 2)) begin
            report_error($sformatf("hit at %h answered after %0d cycles, expected 2",
                                   e.addr, cycle - int'(e.cycle)));
        end
        if (!e.hit) begin
            if (fill_words != words_per_line) begin
                report_error($sformatf("miss at %h answered after %0d refill reads",
                                       e.addr, fill_words));
            end
            miss_open = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        reset_q <= reset;
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                model_valid[0][s] = 1'b0;
                model_valid[1][s] = 1'b0;
                model_lru[s]      = 1'b0;
            end
            exp_q.delete();
            cycle       = 0;
            miss_open   = 1'b0;
            fill_words  = 0;
            error_count = 0;
            hit_count   = 0;
            miss_count  = 0;
        end else begin
            cycle = cycle + 1;
            if (reset_q && (wb_m.cyc || wb_m.stb || fetch_rsp.valid || !req_ready)) begin
                report_error("outputs not idle right after reset");
            end
            if (miss_open && req_ready && !fetch_rsp.valid) begin
                report_error("req_ready high while a miss is outstanding");
            end
            check_bus();
            check_response();
            if (fetch_req.valid && req_ready) begin
                accept_request(fetch_req.addr);
            end
        end
        pending <= exp_q.size();
    end

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire icache_pkg::fetch_req_t stage_req,  // request whose RAM read is out
    input  wire icache_pkg::tag_t       tag0_rd,
    input  wire icache_pkg::tag_t       tag1_rd,
    input  wire logic                   valid0,
    input  wire logic                   valid1,
    input  wire logic                   lru,
    input  wire icache_pkg::line_t      data0_rd,
    input  wire icache_pkg::line_t      data1_rd,
    output icache_pkg::tag_t            tag_wd,
    output logic                        tag0_we,
    output logic                        tag1_we,
    output logic                        lru_update,
    output logic                        hit_way,
    output logic                        data0_rw,
    output logic                        data1_rw,
    output icache_pkg::line_t           data_wd,
    output logic                        replay,     // RAMs take the staged index
    output logic                        req_ready,
    output icache_pkg::fetch_rsp_t      fetch_rsp,
    output icache_pkg::wb_m2s_t         wb_m,
    input  wire logic                   wb_ack,
    input  wire icache_pkg::word_t      wb_dat
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        s_idle,                                     // compare stage
        s_fetch,                                    // strobe out, waiting for ack
        s_gap,                                      // stb low between words
        s_fill,                                     // write line and tag
        s_replay,                                   // re-read staged set
        s_rehit,                                    // compare on the refilled line
        s_resp                                      // response out, next request taken
    } state_t;

    state_t                state;
    logic [word_sel_w-1:0] word_cnt;                // refill word in flight
    logic                  victim;                  // way being refilled
    line_t                 fill_line;               // collected refill words
    tag_t                  req_tag;
    logic [index_w-1:0]    req_index;
    logic [word_sel_w-1:0] req_word;
    logic                  hit0;
    logic                  hit1;
    logic                  hit;
    logic                  miss;
    word_t                 hit_word;
    logic                  rsp_valid;
    word_t                 rsp_data;

    assign req_tag   = addr_tag(stage_req.addr);
    assign req_index = addr_index(stage_req.addr);
    assign req_word  = addr_word(stage_req.addr);

    // tag compare on both ways
    assign hit0     = valid0 && (tag0_rd == req_tag);
    assign hit1     = valid1 && (tag1_rd == req_tag);
    assign hit      = ((state == s_idle) || (state == s_rehit)) && stage_req.valid
                      && (hit0 || hit1);
    assign miss     = (state == s_idle) && stage_req.valid && !(hit0 || hit1);
    assign hit_way  = hit1;
    assign hit_word = hit1 ? data1_rd[req_word] : data0_rd[req_word];

    assign req_ready  = ((state == s_idle) && !miss) || (state == s_resp);
    assign replay     = !req_ready;                 // stall from miss until the response
    assign lru_update = hit;

    // refill writes
    assign tag_wd   = req_tag;
    assign data_wd  = fill_line;
    assign tag0_we  = (state == s_fill) && !victim;
    assign tag1_we  = (state == s_fill) && victim;
    assign data0_rw = tag0_we;
    assign data1_rw = tag1_we;

    // Wishbone classic with one single read per word of the line
    assign wb_m = '{
        cyc: (state == s_fetch) || (state == s_gap),
        stb: (state == s_fetch),
        we:  1'b0,
        adr: {req_tag, req_index, word_cnt, 2'b00},
        sel: '1
    };

    assign fetch_rsp = '{valid: rsp_valid, data: rsp_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= s_idle;
            word_cnt <= '0;
            victim   <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (miss) begin
                        state    <= s_fetch;
                        word_cnt <= '0;
                        // invalid way first then the LRU way
                        victim   <= !valid0 ? 1'b0 : (!valid1 ? 1'b1 : lru);
                    end
                end
                s_fetch: begin
                    if (wb_ack) begin
                        if (word_cnt == word_sel_w'(words_per_line - 1)) begin
                            state <= s_fill;        // last word in
                        end else begin
                            state <= s_gap;
                        end
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                s_gap:    state <= s_fetch;
                s_fill:   state <= s_replay;        // read here still sees old line
                s_replay: state <= s_rehit;         // compare sees new line next
                s_rehit:  state <= s_resp;          // replayed hit registers the word
                s_resp:   state <= s_idle;
                default:  state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == s_fetch) && wb_ack) begin
            fill_line[word_cnt] <= wb_dat;
        end
    end

    always_ff @(posedge clk) begin
        rsp_data <= hit_word;
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= hit;                       // one cycle per hit
        end
    end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    localparam int addr_w         = 32;
    localparam int index_w        = 8;                           // 256 sets
    localparam int offset_w       = 4;                           // 16-byte lines
    localparam int tag_w          = addr_w - index_w - offset_w; // 20
    localparam int words_per_line = 4;
    localparam int num_sets       = 1 << index_w;
    localparam int word_sel_w     = offset_w - 2;                // word within line

    typedef logic [tag_w-1:0]             tag_t;
    typedef logic [31:0]                  word_t;
    typedef word_t [words_per_line-1:0]   line_t;                // word 0 in low bits

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;    // byte address, word aligned
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } fetch_rsp_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;      // always low, read only master
        logic [addr_w-1:0] adr;     // word aligned
        logic [3:0]        sel;
    } wb_m2s_t;

    // address split: tag 31..12, index 11..4, word 3..2
    function automatic tag_t addr_tag(input logic [addr_w-1:0] addr);
        return addr[addr_w-1 -: tag_w];
    endfunction

    function automatic logic [index_w-1:0] addr_index(input logic [addr_w-1:0] addr);
        return addr[offset_w +: index_w];
    endfunction

    function automatic logic [word_sel_w-1:0] addr_word(input logic [addr_w-1:0] addr);
        return addr[2 +: word_sel_w];
    endfunction

endpackage

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire icache_pkg::fetch_req_t fetch_req,
    output logic                        req_ready,
    output icache_pkg::fetch_rsp_t      fetch_rsp,
    output icache_pkg::wb_m2s_t         wb_m,
    input  wire logic                   wb_ack,
    input  wire icache_pkg::word_t      wb_dat
);
    import icache_pkg::*;

    fetch_req_t         stage_req;                  // lookup stage register
    logic [index_w-1:0] ram_index;
    logic               replay;
    tag_t               tag0_rd;
    tag_t               tag1_rd;
    tag_t               tag_wd;
    logic               valid0;
    logic               valid1;
    logic               lru;
    logic               tag0_we;
    logic               tag1_we;
    logic               lru_update;
    logic               hit_way;
    line_t              data0_rd;
    line_t              data1_rd;
    line_t              data_wd;
    logic               data0_rw;
    logic               data1_rw;

    // loads on accept, holds while stalled
    always_ff @(posedge clk) begin
        if (req_ready) begin
            stage_req.addr <= fetch_req.addr;
        end
        if (reset) begin
            stage_req.valid <= 1'b0;
        end else if (req_ready) begin
            stage_req.valid <= fetch_req.valid;     // bubble when no request
        end
    end

    // new request reads the RAMs at its accept edge, a stall re-presents the staged set
    assign ram_index = replay ? addr_index(stage_req.addr) : addr_index(fetch_req.addr);

    itag_ram u_itag_ram (
        .clk        (clk),
        .reset      (reset),
        .index      (ram_index),
        .tag_wd     (tag_wd),
        .tag0_we    (tag0_we),
        .tag1_we    (tag1_we),
        .lru_update (lru_update),
        .hit_way    (hit_way),
        .tag0_rd    (tag0_rd),
        .tag1_rd    (tag1_rd),
        .valid0     (valid0),
        .valid1     (valid1),
        .lru        (lru)
    );

    idata_ram u_idata_ram (
        .clk      (clk),
        .index    (ram_index),
        .data0_rw (data0_rw),
        .data1_rw (data1_rw),
        .data_wd  (data_wd),
        .data0_rd (data0_rd),
        .data1_rd (data1_rd)
    );

    icache_ctrl u_icache_ctrl (
        .clk        (clk),
        .reset      (reset),
        .stage_req  (stage_req),
        .tag0_rd    (tag0_rd),
        .tag1_rd    (tag1_rd),
        .valid0     (valid0),
        .valid1     (valid1),
        .lru        (lru),
        .data0_rd   (data0_rd),
        .data1_rd   (data1_rd),
        .tag_wd     (tag_wd),
        .tag0_we    (tag0_we),
        .tag1_we    (tag1_we),
        .lru_update (lru_update),
        .hit_way    (hit_way),
        .data0_rw   (data0_rw),
        .data1_rw   (data1_rw),
        .data_wd    (data_wd),
        .replay     (replay),
        .req_ready  (req_ready),
        .fetch_rsp  (fetch_rsp),
        .wb_m       (wb_m),
        .wb_ack     (wb_ack),
        .wb_dat     (wb_dat)
    );

endmodule

`default_nettype wire

// ==== idata_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module idata_ram (
    input  wire logic                           clk,
    input  wire logic [icache_pkg::index_w-1:0] index,      // set of both ways
    input  wire logic                           data0_rw,   // refill way 0
    input  wire logic                           data1_rw,   // refill way 1
    input  wire icache_pkg::line_t              data_wd,    // refill line, shared by ways
    output wire icache_pkg::line_t              data0_rd,
    output wire icache_pkg::line_t              data1_rd
);
    import icache_pkg::*;

    // each way is one 32-bit bank per word of the line
    // all banks of a way share address and write enable, so a refill
    // lands the whole line in one cycle
    for (genvar b = 0; b < words_per_line; b++) begin : g_bank
        sram_256 #(
            .entry_t (word_t)
        ) way0_bank (
            .clk     (clk),
            .address (index),
            .wren    (data0_rw),
            .data    (data_wd[b]),     // word b of refill line
            .q       (data0_rd[b])
        );

        sram_256 #(
            .entry_t (word_t)
        ) way1_bank (
            .clk     (clk),
            .address (index),
            .wren    (data1_rw),
            .data    (data_wd[b]),     // same word feeds both ways
            .q       (data1_rd[b])
        );
    end

endmodule

`default_nettype wire

// ==== itag_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module itag_ram (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [icache_pkg::index_w-1:0] index,      // lookup set
    input  wire icache_pkg::tag_t               tag_wd,     // tag of refilled line
    input  wire logic                           tag0_we,
    input  wire logic                           tag1_we,
    input  wire logic                           lru_update, // hit in compare stage
    input  wire logic                           hit_way,
    output icache_pkg::tag_t                    tag0_rd,
    output icache_pkg::tag_t                    tag1_rd,
    output logic                                valid0,
    output logic                                valid1,
    output logic                                lru         // names the victim way
);
    import icache_pkg::*;

    logic [num_sets-1:0] valid0_bits;
    logic [num_sets-1:0] valid1_bits;
    logic [num_sets-1:0] lru_bits;
    logic [index_w-1:0]  index_q;                           // set now in compare stage

    sram_256 #(
        .entry_t (tag_t)
    ) tag_way0 (
        .clk     (clk),
        .address (index),
        .wren    (tag0_we),
        .data    (tag_wd),
        .q       (tag0_rd)
    );

    sram_256 #(
        .entry_t (tag_t)
    ) tag_way1 (
        .clk     (clk),
        .address (index),
        .wren    (tag1_we),
        .data    (tag_wd),
        .q       (tag1_rd)
    );

    always_ff @(posedge clk) begin
        index_q <= index;
        if (reset) begin
            valid0_bits <= '0;                              // whole cache invalid
            valid1_bits <= '0;
            lru_bits    <= '0;
            valid0      <= 1'b0;
            valid1      <= 1'b0;
            lru         <= 1'b0;
        end else begin
            if (tag0_we) begin
                valid0_bits[index] <= 1'b1;                 // same set as tag write
            end
            if (tag1_we) begin
                valid1_bits[index] <= 1'b1;
            end
            if (lru_update) begin
                lru_bits[index_q] <= ~hit_way;              // other way becomes victim
            end
            valid0 <= valid0_bits[index];                   // aligned with tag RAM read
            valid1 <= valid1_bits[index];
            // a hit on the same set at this edge must reach the next lookup
            if (lru_update && (index_q == index)) begin
                lru <= ~hit_way;
            end else begin
                lru <= lru_bits[index];
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
# the run passes only if the log carries the pass line
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_icache -f vlog.f -o tb_icache \
    && ./obj_dir/tb_icache | tee sim.log
grep -qs "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sram_256.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_256 #(
    parameter type entry_t = icache_pkg::word_t             // data bank or tag entry
) (
    input  wire logic                           clk,
    input  wire logic [icache_pkg::index_w-1:0] address,    // set index
    input  wire logic                           wren,
    input  wire entry_t                         data,
    output entry_t                              q           // registered read
);
    import icache_pkg::*;

    entry_t mem [num_sets];                                 // one entry per set

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;                           // write at the edge
        end
        q <= mem[address];                                  // old data on a write cycle
    end

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int num_random  = 400;                    // fetches after the directed part
    localparam int ready_limit = 100;                    // cycles a request may wait
    localparam int drain_limit = 100;

    logic        clk;
    logic        reset     = 1'b1;
    fetch_req_t  fetch_req = '0;
    logic        req_ready;
    fetch_rsp_t  fetch_rsp;
    wb_m2s_t     wb_m;
    logic        wb_ack    = 1'b0;
    word_t       wb_dat    = '0;
    int          error_count;
    int          pending;
    int          hit_count;
    int          miss_count;
    int          tb_failures;                            // timeouts
    int          stim_seed;
    int          wait_seed;
    int          wait_left = -1;                         // wait states left on this strobe
    logic [19:0] tag_pool   [4];
    logic [7:0]  index_pool [4];

    icache_top UUT (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .req_ready (req_ready),
        .fetch_rsp (fetch_rsp),
        .wb_m      (wb_m),
        .wb_ack    (wb_ack),
        .wb_dat    (wb_dat)
    );

    icache_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .req_ready   (req_ready),
        .fetch_rsp   (fetch_rsp),
        .wb_m        (wb_m),
        .wb_ack      (wb_ack),
        .error_count (error_count),
        .pending     (pending),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory image is the address xored with a constant then rotated by bits 6..2
    function automatic word_t mem_word(input logic [31:0] addr);
        logic [31:0] x;
        logic [4:0]  r;
        x = addr ^ 32'h5a3c_96e1;
        r = addr[6:2];
        return (x << r) | (x >> (6'd32 - {1'b0, r}));
    endfunction

    // Wishbone classic slave with 0 to 3 wait states per strobe
    always @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            wait_left = -1;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;                              // one-cycle ack
        end else if (wb_m.cyc && wb_m.stb) begin
            if (wait_left < 0) wait_left = $random(wait_seed) & 3;
            if (wait_left == 0) begin
                wb_ack    <= 1'b1;
                wb_dat    <= mem_word(wb_m.adr);
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic pick_addr(output logic [31:0] addr);
        logic [31:0] r;
        r = $random(stim_seed);
        addr = {tag_pool[r[1:0]], index_pool[r[3:2]], r[5:4], 2'b00};
    endtask

    // drive a request and hold it until the edge that accepts it
    task automatic issue_fetch(input logic [31:0] addr);
        int waited;
        fetch_req <= '{valid: 1'b1, addr: addr};
        waited = 0;
        @(posedge clk);
        while (!req_ready && (waited < ready_limit)) begin
            waited++;
            @(posedge clk);
        end
        if (!req_ready) begin
            $display("Timeout: fetch of %h not accepted within %0d cycles", addr, ready_limit);
            tb_failures++;
        end
    endtask

    task automatic idle_cycle();
        fetch_req <= '0;
        @(posedge clk);
    endtask

    // set 0x40 lies outside the random pool, so it starts empty
    task automatic eviction_sequence();
        issue_fetch({tag_pool[0], 8'h40, 4'h0});         // miss fills way 0
        issue_fetch({tag_pool[1], 8'h40, 4'h4});         // miss fills way 1
        issue_fetch({tag_pool[2], 8'h40, 4'h8});         // evicts way 0
        issue_fetch({tag_pool[1], 8'h40, 4'hc});         // survivor hits
        issue_fetch({tag_pool[0], 8'h40, 4'h0});         // evicted tag misses again
    endtask

    initial begin
        int          n;
        int          waited;
        logic [31:0] r;
        logic [31:0] addr;
        stim_seed     = 32'h8f94e73a;
        wait_seed     = 32'h8f94e73a;
        tb_failures   = 0;
        tag_pool[0]   = 20'h00010;
        tag_pool[1]   = 20'h00023;
        tag_pool[2]   = 20'h0abcd;
        tag_pool[3]   = 20'hfffff;                       // four tags over two ways
        index_pool[0] = 8'h00;
        index_pool[1] = 8'h01;
        index_pool[2] = 8'h7f;
        index_pool[3] = 8'hff;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        eviction_sequence();
        for (n = 0; (n < num_random) && (tb_failures == 0); n++) begin
            r = $random(stim_seed);
            if (r[2:0] == 3'd0) begin
                idle_cycle();                            // bubble about one in eight
            end else begin
                pick_addr(addr);
                issue_fetch(addr);
            end
        end
        fetch_req <= '0;
        waited = 0;
        @(posedge clk);
        while ((pending != 0) && (waited < drain_limit)) begin
            waited++;
            @(posedge clk);
        end
        if (pending != 0) begin
            $display("Timeout: %0d responses never arrived", pending);
            tb_failures++;
        end
        @(negedge clk);                                  // counts settled
        $display("errors %0d, testbench failures %0d, hits %0d, misses %0d",
                 error_count, tb_failures, hit_count, miss_count);
        if ((error_count == 0) && (tb_failures == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
icache_pkg.sv
sram_256.sv
idata_ram.sv
itag_ram.sv
icache_ctrl.sv
icache_top.sv
icache_checker.sv
tb_icache.sv
